//--- src/bexkat_pkg.sv
`default_nettype none

package bexkat_pkg;

  localparam int WORD_W     = 32;
  localparam int HALF_W     = 16;
  localparam int REG_ADDR_W = 5;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [HALF_W-1:0]     half_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [3:0]            ccr_t;   // carry, negative, overflow, zero

  localparam word_t RESET_PC_DEFAULT = 32'hffc0_0000;

  // bit positions inside ccr_t
  localparam int CCR_C = 3;
  localparam int CCR_N = 2;
  localparam int CCR_V = 1;
  localparam int CCR_Z = 0;

  // instruction register fields, first halfword in the upper half
  localparam int MODE_MSB = 31;
  localparam int MODE_LSB = 29;
  localparam int OP_MSB   = 28;
  localparam int OP_LSB   = 21;   // full 8-bit op of the upper modes
  localparam int OPG_LSB  = 26;   // op group bits
  localparam int OPL_MSB  = 15;   // op low bits, second halfword
  localparam int OPL_LSB  = 11;
  localparam int RB_MSB   = 25;
  localparam int RB_LSB   = 21;
  localparam int RA_MSB   = 20;
  localparam int RA_LSB   = 16;
  localparam int RC_MSB   = 4;
  localparam int RC_LSB   = 0;

  typedef enum logic [2:0] {
    MODE_INH2   = 3'h0,
    MODE_IMM3   = 3'h1,
    MODE_REGIND = 3'h2,
    MODE_REG    = 3'h3,
    MODE_INH    = 3'h4,
    MODE_IMM2   = 3'h5,
    MODE_DIR    = 3'h6,
    MODE_IMM3A  = 3'h7
  } mode_e;

  typedef enum logic [3:0] {
    ALU_AND = 4'h0,
    ALU_OR  = 4'h1,
    ALU_ADD = 4'h2,
    ALU_SUB = 4'h3,
    ALU_LSL = 4'h4,
    ALU_ASR = 4'h5,
    ALU_LSR = 4'h6,
    ALU_XOR = 4'h7
  } alu_op_e;

  typedef enum logic [2:0] {
    FETCH1,
    FETCH2,
    FETCH3,
    EXEC,
    MEM_WAIT,
    FAULT
  } cpu_state_e;

endpackage

`default_nettype wire

//--- src/bexkat_alu.sv
`default_nettype none

module bexkat_alu (
  input  bexkat_pkg::word_t   a,
  input  bexkat_pkg::word_t   b,
  input  bexkat_pkg::alu_op_e op,
  output bexkat_pkg::word_t   y,
  output bexkat_pkg::ccr_t    flags
);

  import bexkat_pkg::*;

  localparam int SH_W = $clog2(WORD_W);

  logic [WORD_W:0] sum;   // extra bit is carry/borrow
  logic            carry;
  logic            overflow;

  always_comb begin
    y        = '0;
    sum      = '0;
    carry    = 1'b0;
    overflow = 1'b0;
    case (op)
      ALU_AND: y = a & b;
      ALU_OR:  y = a | b;
      ALU_ADD: begin
        sum      = {1'b0, a} + {1'b0, b};
        y        = sum[WORD_W-1:0];
        carry    = sum[WORD_W];
        overflow = (a[WORD_W-1] == b[WORD_W-1]) && (y[WORD_W-1] != a[WORD_W-1]);
      end
      ALU_SUB: begin
        sum      = {1'b0, a} - {1'b0, b};
        y        = sum[WORD_W-1:0];
        carry    = sum[WORD_W];   // borrow
        overflow = (a[WORD_W-1] != b[WORD_W-1]) && (y[WORD_W-1] != a[WORD_W-1]);
      end
      ALU_LSL: y = a << b[SH_W-1:0];
      ALU_ASR: y = word_t'($signed(a) >>> b[SH_W-1:0]);
      ALU_LSR: y = a >> b[SH_W-1:0];
      ALU_XOR: y = a ^ b;
      default: y = '0;
    endcase
  end

  assign flags = {carry, y[WORD_W-1], overflow, (y == '0)};

endmodule

`default_nettype wire

//--- src/bexkat_regfile.sv
`default_nettype none

module bexkat_regfile (
  input  wire                   csi_clk,
  input  wire                   rsi_reset_n,
  input  bexkat_pkg::reg_addr_t rd_addr_a,
  input  bexkat_pkg::reg_addr_t rd_addr_b,
  input  bexkat_pkg::reg_addr_t wr_addr,
  input  wire                   wr_en,
  input  bexkat_pkg::word_t     wr_data,
  output bexkat_pkg::word_t     rd_data_a,
  output bexkat_pkg::word_t     rd_data_b
);

  import bexkat_pkg::*;

  localparam int NUM_REGS = 2 ** $bits(reg_addr_t);

  word_t regs [NUM_REGS];

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // same-cycle write is not forwarded
  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

//--- src/bexkat_bus_master.sv
`default_nettype none

module bexkat_bus_master (
  input  wire               csi_clk,
  input  wire               rsi_reset_n,
  input  wire               bus_req,
  input  wire               bus_we,
  input  wire               bus_long,
  input  bexkat_pkg::word_t bus_addr,
  input  bexkat_pkg::word_t bus_wdata,
  output logic              bus_done,
  output bexkat_pkg::word_t bus_rdata,
  input  wire               avm_m0_waitrequest,
  input  bexkat_pkg::half_t avm_m0_readdata,
  output bexkat_pkg::word_t avm_m0_address,
  output logic              avm_m0_read,
  output logic              avm_m0_write,
  output bexkat_pkg::half_t avm_m0_writedata,
  output logic [1:0]        avm_m0_byteenable
);

  import bexkat_pkg::*;

  typedef enum logic [1:0] {BM_IDLE, BM_XFER, BM_DONE} bm_state_e;

  bm_state_e bm_state;
  logic      last;      // current transfer is the final half
  logic      xfer_ack;

  assign xfer_ack          = (bm_state == BM_XFER) && !avm_m0_waitrequest;
  assign bus_done          = (bm_state == BM_DONE);
  assign avm_m0_byteenable = 2'b11;

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      bm_state       <= BM_IDLE;
      last           <= 1'b0;
      avm_m0_read    <= 1'b0;
      avm_m0_write   <= 1'b0;
      avm_m0_address <= '0;
    end else begin
      case (bm_state)
        BM_IDLE: if (bus_req) begin
          avm_m0_address <= bus_addr;
          avm_m0_read    <= !bus_we;
          avm_m0_write   <= bus_we;
          last           <= !bus_long;
          bm_state       <= BM_XFER;
        end
        BM_XFER: if (xfer_ack) begin
          if (last) begin
            avm_m0_read  <= 1'b0;
            avm_m0_write <= 1'b0;
            bm_state     <= BM_DONE;
          end else begin
            avm_m0_address <= avm_m0_address + 32'd2;   // lower half next
            last           <= 1'b1;
          end
        end
        default: bm_state <= BM_IDLE;   // done pulse lasts one cycle
      endcase
    end
  end

  always_ff @(posedge csi_clk) begin
    if (bm_state == BM_IDLE && bus_req) begin
      avm_m0_writedata <= bus_long ? bus_wdata[WORD_W-1:HALF_W] : bus_wdata[HALF_W-1:0];
    end else if (xfer_ack && !last) begin
      avm_m0_writedata <= bus_wdata[HALF_W-1:0];
    end
    if (xfer_ack) begin
      if (!last) begin
        bus_rdata[WORD_W-1:HALF_W] <= avm_m0_readdata;
      end else if (bus_long) begin
        bus_rdata[HALF_W-1:0] <= avm_m0_readdata;
      end else begin
        bus_rdata <= {{HALF_W{1'b0}}, avm_m0_readdata};
      end
    end
  end

  a_hold_on_wait: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
    (avm_m0_read || avm_m0_write) && avm_m0_waitrequest |=>
      $stable(avm_m0_address) && $stable(avm_m0_read) && $stable(avm_m0_write)
      && $stable(avm_m0_writedata));

endmodule

`default_nettype wire

//--- src/bexkat_control.sv
`default_nettype none

module bexkat_control #(
  parameter bexkat_pkg::word_t RESET_PC = bexkat_pkg::RESET_PC_DEFAULT
) (
  input  wire                   csi_clk,
  input  wire                   rsi_reset_n,
  input  wire                   bus_done,
  input  bexkat_pkg::word_t     bus_rdata,
  input  bexkat_pkg::word_t     rd_data_a,
  input  bexkat_pkg::word_t     rd_data_b,
  input  bexkat_pkg::word_t     alu_y,
  input  bexkat_pkg::ccr_t      alu_flags,
  output logic                  bus_req,
  output logic                  bus_we,
  output logic                  bus_long,
  output bexkat_pkg::word_t     bus_addr,
  output bexkat_pkg::word_t     bus_wdata,
  output bexkat_pkg::reg_addr_t rd_addr_a,
  output bexkat_pkg::reg_addr_t rd_addr_b,
  output bexkat_pkg::reg_addr_t wr_addr,
  output logic                  wr_en,
  output bexkat_pkg::word_t     wr_data,
  output bexkat_pkg::alu_op_e   alu_op,
  output bexkat_pkg::word_t     alu_b,
  output logic                  fault
);

  import bexkat_pkg::*;

  cpu_state_e state, state_next;
  word_t      pc, pc_next;
  word_t      ir;
  word_t      mar;   // branch offset or direct address
  word_t      mdr;   // long immediate
  ccr_t       ccr, ccr_next;

  mode_e      ir_mode;
  mode_e      fetch_mode;
  logic [7:0] ir_op;
  reg_addr_t  ir_ra, ir_rb, ir_rc;
  logic       br_taken;
  logic       br_valid;

  assign ir_mode    = mode_e'(ir[MODE_MSB:MODE_LSB]);
  assign fetch_mode = mode_e'(bus_rdata[MODE_MSB-HALF_W:MODE_LSB-HALF_W]);
  assign ir_ra      = ir[RA_MSB:RA_LSB];
  assign ir_rb      = ir[RB_MSB:RB_LSB];
  assign ir_rc      = ir[RC_MSB:RC_LSB];
  assign fault      = (state == FAULT);

  always_comb begin
    if (!ir[MODE_MSB]) begin
      ir_op = {ir[OP_MSB:OPG_LSB], ir[OPL_MSB:OPL_LSB]};
    end else if (ir_mode == MODE_INH) begin
      ir_op = {ir[OP_MSB:OPG_LSB], 5'b00000};
    end else begin
      ir_op = ir[OP_MSB:OP_LSB];
    end
  end

  always_comb begin
    br_valid = 1'b1;
    case (ir_op[3:0])
      4'h0: br_taken = 1'b1;                                    // bra
      4'h1: br_taken = ccr[CCR_Z];                              // beq
      4'h2: br_taken = !ccr[CCR_Z];                             // bne
      4'h3: br_taken = !(ccr[CCR_Z] | ccr[CCR_C]);              // bgtu
      4'h4: br_taken = !(ccr[CCR_Z] | (ccr[CCR_N] ^ ccr[CCR_V]));
      4'h5: br_taken = !(ccr[CCR_N] ^ ccr[CCR_V]);              // bge
      4'h6: br_taken = ccr[CCR_Z] | (ccr[CCR_N] ^ ccr[CCR_V]);  // ble
      4'h7: br_taken = ccr[CCR_N] ^ ccr[CCR_V];                 // blt
      4'h8: br_taken = !ccr[CCR_C];                             // bgeu
      4'h9: br_taken = ccr[CCR_C];                              // bltu
      4'ha: br_taken = ccr[CCR_C] | ccr[CCR_Z];                 // bleu
      4'hb: br_taken = 1'b0;                                    // brn
      default: begin
        br_taken = 1'b0;
        br_valid = 1'b0;
      end
    endcase
  end

  always_comb begin
    state_next = state;
    pc_next    = pc;
    ccr_next   = ccr;
    bus_req    = 1'b0;
    bus_we     = 1'b0;
    bus_long   = 1'b0;
    bus_addr   = pc;
    bus_wdata  = rd_data_a;
    rd_addr_a  = ir_ra;
    rd_addr_b  = ir_rb;
    wr_addr    = ir_ra;
    wr_en      = 1'b0;
    wr_data    = alu_y;
    alu_op     = ALU_ADD;
    alu_b      = rd_data_b;
    case (state)
      FETCH1: begin
        bus_req = 1'b1;
        if (bus_done) begin
          pc_next = pc + 32'd2;
          case (fetch_mode)
            MODE_INH: state_next = EXEC;
            MODE_REG, MODE_IMM2, MODE_IMM3, MODE_IMM3A, MODE_DIR: state_next = FETCH2;
            default: state_next = FAULT;
          endcase
        end
      end
      FETCH2: begin
        bus_req = 1'b1;
        if (bus_done) begin
          pc_next    = pc + 32'd2;
          state_next = (ir_mode == MODE_REG || ir_mode == MODE_IMM2) ? EXEC : FETCH3;
        end
      end
      FETCH3: begin
        bus_req = 1'b1;
        if (bus_done) begin
          pc_next    = pc + 32'd2;
          state_next = EXEC;
        end
      end
      EXEC: begin
        state_next = FETCH1;
        casez ({ir_mode, ir_op})
          {MODE_INH, 8'h00}: state_next = FETCH1;   // nop
          {MODE_INH, 8'h40}: begin   // cmp
            alu_op   = ALU_SUB;
            ccr_next = alu_flags;
          end
          {MODE_INH, 8'h60}: begin   // inc
            alu_b = 32'd1;
            wr_en = 1'b1;
          end
          {MODE_INH, 8'h80}: begin   // dec
            alu_op = ALU_SUB;
            alu_b  = 32'd1;
            wr_en  = 1'b1;
          end
          {MODE_INH, 8'he0}: begin   // mov
            rd_addr_a = ir_rb;
            wr_data   = rd_data_a;
            wr_en     = 1'b1;
          end
          {MODE_IMM2, 8'b???1???0}: begin   // ldis
            wr_data = mar;
            wr_en   = 1'b1;
          end
          {MODE_IMM2, 8'b???1???1}: begin   // ldiu
            wr_data = {16'h0000, ir[15:0]};
            wr_en   = 1'b1;
          end
          {MODE_IMM2, 8'b???0????}: begin
            if (!br_valid) begin
              state_next = FAULT;
            end else if (br_taken) begin
              pc_next = pc + mar;   // pc already past the instruction
            end
          end
          {MODE_REG, 8'b??0?0???}: begin
            rd_addr_a = ir_rb;
            rd_addr_b = ir_rc;
            alu_op    = alu_op_e'({1'b0, ir_op[2:0]});
            wr_en     = 1'b1;
          end
          {MODE_IMM3, 8'b00000???}: begin
            rd_addr_a = ir_rb;
            alu_b     = {{16{mdr[15]}}, mdr[15:0]};
            alu_op    = alu_op_e'({1'b0, ir_op[2:0]});
            wr_en     = 1'b1;
          end
          {MODE_IMM3A, 8'h00}: begin   // ldi
            wr_data = mdr;
            wr_en   = 1'b1;
          end
          {MODE_DIR, 8'b000000??}: state_next = MEM_WAIT;   // std.l ldd.l std ldd
          {MODE_DIR, 8'h80}: pc_next = mar;   // jmpd
          default: state_next = FAULT;
        endcase
      end
      MEM_WAIT: begin
        bus_req  = 1'b1;
        bus_we   = !ir_op[0];
        bus_long = !ir_op[1];
        bus_addr = mar;
        wr_data  = bus_rdata;   // short reads arrive zero extended
        if (bus_done) begin
          wr_en      = ir_op[0];
          state_next = FETCH1;
        end
      end
      default: state_next = FAULT;   // sticky
    endcase
  end

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      state <= FETCH1;
      pc    <= RESET_PC;
      ccr   <= '0;
    end else begin
      state <= state_next;
      pc    <= pc_next;
      ccr   <= ccr_next;
    end
  end

  always_ff @(posedge csi_clk) begin
    if (bus_done) begin
      case (state)
        FETCH1: ir[31:16] <= bus_rdata[15:0];
        FETCH2: begin
          ir[15:0] <= bus_rdata[15:0];
          mar      <= {{16{bus_rdata[15]}}, bus_rdata[15:0]};
        end
        FETCH3: begin
          if (ir_mode == MODE_DIR) begin
            mar <= {ir[15:0], bus_rdata[15:0]};
          end else begin
            mdr <= {ir[15:0], bus_rdata[15:0]};
          end
        end
        default: ;
      endcase
    end
  end

  a_fault_quiet: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
    (state == FAULT) |=> (state == FAULT) && !bus_req);

  a_wr_en_state: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
    wr_en |-> (state == EXEC) || (state == MEM_WAIT && bus_done));

endmodule

`default_nettype wire

//--- src/bexkat_core.sv
`default_nettype none

module bexkat_core #(
  parameter bexkat_pkg::word_t RESET_PC = bexkat_pkg::RESET_PC_DEFAULT
) (
  input  wire               csi_clk,
  input  wire               rsi_reset_n,
  input  wire               avm_m0_waitrequest,
  input  bexkat_pkg::half_t avm_m0_readdata,
  output bexkat_pkg::word_t avm_m0_address,
  output logic              avm_m0_read,
  output logic              avm_m0_write,
  output bexkat_pkg::half_t avm_m0_writedata,
  output logic [1:0]        avm_m0_byteenable,
  output logic              fault
);

  import bexkat_pkg::*;

  logic      bus_req, bus_we, bus_long, bus_done;
  word_t     bus_addr, bus_wdata, bus_rdata;
  reg_addr_t rd_addr_a, rd_addr_b, wr_addr;
  logic      wr_en;
  word_t     wr_data, rd_data_a, rd_data_b;
  alu_op_e   alu_op;
  word_t     alu_b, alu_y;
  ccr_t      alu_flags;

  bexkat_control #(
    .RESET_PC (RESET_PC)
  ) i_control (
    .csi_clk     (csi_clk),
    .rsi_reset_n (rsi_reset_n),
    .bus_done    (bus_done),
    .bus_rdata   (bus_rdata),
    .rd_data_a   (rd_data_a),
    .rd_data_b   (rd_data_b),
    .alu_y       (alu_y),
    .alu_flags   (alu_flags),
    .bus_req     (bus_req),
    .bus_we      (bus_we),
    .bus_long    (bus_long),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .rd_addr_a   (rd_addr_a),
    .rd_addr_b   (rd_addr_b),
    .wr_addr     (wr_addr),
    .wr_en       (wr_en),
    .wr_data     (wr_data),
    .alu_op      (alu_op),
    .alu_b       (alu_b),
    .fault       (fault)
  );

  bexkat_regfile i_regfile (
    .csi_clk     (csi_clk),
    .rsi_reset_n (rsi_reset_n),
    .rd_addr_a   (rd_addr_a),
    .rd_addr_b   (rd_addr_b),
    .wr_addr     (wr_addr),
    .wr_en       (wr_en),
    .wr_data     (wr_data),
    .rd_data_a   (rd_data_a),
    .rd_data_b   (rd_data_b)
  );

  bexkat_alu i_alu (
    .a     (rd_data_a),   // first operand always from port a
    .b     (alu_b),
    .op    (alu_op),
    .y     (alu_y),
    .flags (alu_flags)
  );

  bexkat_bus_master i_bus_master (
    .csi_clk            (csi_clk),
    .rsi_reset_n        (rsi_reset_n),
    .bus_req            (bus_req),
    .bus_we             (bus_we),
    .bus_long           (bus_long),
    .bus_addr           (bus_addr),
    .bus_wdata          (bus_wdata),
    .bus_done           (bus_done),
    .bus_rdata          (bus_rdata),
    .avm_m0_waitrequest (avm_m0_waitrequest),
    .avm_m0_readdata    (avm_m0_readdata),
    .avm_m0_address     (avm_m0_address),
    .avm_m0_read        (avm_m0_read),
    .avm_m0_write       (avm_m0_write),
    .avm_m0_writedata   (avm_m0_writedata),
    .avm_m0_byteenable  (avm_m0_byteenable)
  );

endmodule

`default_nettype wire

//--- dv/tb_bexkat_mem.sv
`default_nettype none

module tb_bexkat_mem #(
  parameter bexkat_pkg::word_t BASE = bexkat_pkg::RESET_PC_DEFAULT,
  parameter logic [31:0]       SEED = 32'h1
) (
  input  wire               csi_clk,
  input  bexkat_pkg::word_t avm_address,
  input  wire               avm_read,
  input  wire               avm_write,
  input  bexkat_pkg::half_t avm_writedata,
  output logic              avm_waitrequest,
  output bexkat_pkg::half_t avm_readdata
);

  timeunit 1ns;
  timeprecision 100ps;

  import bexkat_pkg::*;

  localparam int DEPTH = 65536;

  half_t mem [0:DEPTH-1];
  word_t offset;

  assign offset = avm_address - BASE;

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = half_t'(i) ^ 16'h5a3c;   // fill varies with every address bit
    end
  end

  // waitrequest and readdata change on the falling edge only
  initial begin
    avm_waitrequest = 1'b0;
    avm_readdata    = '0;
    void'($urandom(SEED));
    forever begin
      @(negedge csi_clk);
      avm_waitrequest = ($urandom % 3) == 0;
      if (avm_read && offset < 2 * DEPTH) begin
        avm_readdata = mem[offset >> 1];
      end else begin
        avm_readdata = 16'hdead;   // idle or outside the modelled window
      end
    end
  end

  always @(posedge csi_clk) begin
    if (avm_write && !avm_waitrequest && offset < 2 * DEPTH) begin
      mem[offset >> 1] <= avm_writedata;
    end
  end

endmodule

`default_nettype wire

//--- dv/tb_bexkat_core.sv
`default_nettype none

module tb_bexkat_core;

  timeunit 1ns;
  timeprecision 100ps;

  import bexkat_pkg::*;

  localparam word_t BASE    = RESET_PC_DEFAULT;
  localparam word_t DATA    = BASE + 32'h0001_0000;
  localparam word_t RES     = DATA + 32'h0000_0100;
  localparam word_t MARK    = DATA + 32'h0000_0800;
  localparam word_t BAD     = DATA + 32'h0000_0900;
  localparam int    TIMEOUT = 100000;

  logic  csi_clk, rsi_reset_n;
  logic  avm_m0_waitrequest, avm_m0_read, avm_m0_write, fault;
  half_t avm_m0_readdata, avm_m0_writedata;
  word_t avm_m0_address;
  logic [1:0] avm_m0_byteenable;

  int    errors;
  word_t pc_a;          // assembler location counter
  int    res_n;
  word_t exp_addr[$];   // expected halfword stores in order
  half_t exp_data[$];
  word_t targets[$];    // expected fetch discontinuities
  logic  fetch_seen;
  word_t last_fetch;
  logic  p_busy, p_rd, p_wr;
  word_t p_addr;
  half_t p_wd;

  bexkat_core #(.RESET_PC(BASE)) i_dut (
    .csi_clk            (csi_clk),
    .rsi_reset_n        (rsi_reset_n),
    .avm_m0_waitrequest (avm_m0_waitrequest),
    .avm_m0_readdata    (avm_m0_readdata),
    .avm_m0_address     (avm_m0_address),
    .avm_m0_read        (avm_m0_read),
    .avm_m0_write       (avm_m0_write),
    .avm_m0_writedata   (avm_m0_writedata),
    .avm_m0_byteenable  (avm_m0_byteenable),
    .fault              (fault)
  );

  tb_bexkat_mem #(.BASE(BASE), .SEED(32'h41ccce2d)) i_mem (
    .csi_clk         (csi_clk),
    .avm_address     (avm_m0_address),
    .avm_read        (avm_m0_read),
    .avm_write       (avm_m0_write),
    .avm_writedata   (avm_m0_writedata),
    .avm_waitrequest (avm_m0_waitrequest),
    .avm_readdata    (avm_m0_readdata)
  );

  initial begin
    csi_clk = 1'b0;
    forever #4 csi_clk = ~csi_clk;
  end

  function automatic word_t model_alu(input int op, input word_t a, input word_t b);
    case (op)
      0: return a & b;
      1: return a | b;
      2: return a + b;
      3: return a - b;
      4: return a << b[4:0];
      5: return word_t'({{32{a[31]}}, a} >> b[4:0]);   // sign fill from the top
      6: return a >> b[4:0];
      default: return a ^ b;
    endcase
  endfunction

  function automatic logic branch_taken(input int cond, input word_t a, input word_t b);
    case (cond)
      0: return 1'b1;
      1: return a == b;
      2: return a != b;
      3: return a > b;
      4: return $signed(a) > $signed(b);
      5: return $signed(a) >= $signed(b);
      6: return $signed(a) <= $signed(b);
      7: return $signed(a) < $signed(b);
      8: return a >= b;
      9: return a < b;
      10: return a <= b;
      default: return 1'b0;   // brn
    endcase
  endfunction

  task automatic emit(input half_t h);
    i_mem.mem[(pc_a - BASE) >> 1] = h;
    pc_a += 2;
  endtask

  task automatic put_inh(input int grp, input int rb, input int ra);
    emit({3'b100, 3'(grp), 5'(rb), 5'(ra)});
  endtask

  task automatic put_imm2(input logic [7:0] op, input int ra, input half_t imm);
    emit({3'b101, op, 5'(ra)});
    emit(imm);
  endtask

  task automatic put_ldi(input int ra, input word_t v);
    emit({3'b111, 8'h00, 5'(ra)});
    emit(v[31:16]);
    emit(v[15:0]);
  endtask

  task automatic put_alur(input int op, input int ra, input int rb, input int rc);
    emit({3'b011, 3'b000, 5'(rb), 5'(ra)});
    emit({2'b00, 3'(op), 6'b0, 5'(rc)});
  endtask

  task automatic put_alui(input int op, input int ra, input int rb, input half_t imm);
    emit({3'b001, 3'b000, 5'(rb), 5'(ra)});
    emit({2'b00, 3'(op), 11'b0});
    emit(imm);
  endtask

  task automatic put_dir(input logic [7:0] op, input int ra, input word_t addr);
    emit({3'b110, op, 5'(ra)});
    emit(addr[31:16]);
    emit(addr[15:0]);
  endtask

  task automatic expect_half(input word_t addr, input half_t h);
    exp_addr.push_back(addr);
    exp_data.push_back(h);
  endtask

  task automatic store_l(input int ra, input word_t v);
    word_t addr;
    addr = RES + 4 * res_n;
    res_n++;
    put_dir(8'h00, ra, addr);   // std.l
    expect_half(addr, v[31:16]);
    expect_half(addr + 2, v[15:0]);
  endtask

  task automatic load_program();
    word_t ca[3];
    word_t cb[3];
    int    ra_c[3];
    int    rb_c[3];
    logic  shift;
    logic  taken;
    word_t tgt;
    word_t mv;
    ca = '{32'd5, 32'd3, 32'hffff_ffff};
    cb = '{32'd5, 32'd5, 32'd5};
    ra_c = '{11, 13, 14};
    rb_c = '{12, 11, 11};
    pc_a  = BASE;
    res_n = 0;
    i_mem.mem[(DATA - BASE) >> 1]       = 16'hcafe;
    i_mem.mem[((DATA - BASE) >> 1) + 1] = 16'h1234;
    i_mem.mem[((DATA - BASE) >> 1) + 2] = 16'h9abc;
    put_ldi(1, 32'h1234_5678);
    put_ldi(2, 32'h0f0f_00f3);
    put_imm2(8'h10, 3, 16'h8001);   // ldis
    put_imm2(8'h11, 4, 16'h8001);   // ldiu
    put_imm2(8'h10, 6, 16'h0004);
    put_inh(7, 1, 5);               // mov r5, r1
    put_inh(3, 0, 5);               // inc
    put_inh(4, 0, 4);               // dec
    store_l(3, 32'hffff_8001);
    store_l(4, 32'h0000_8000);
    store_l(5, 32'h1234_5679);
    for (int op = 0; op < 8; op++) begin
      shift = (op >= 4 && op <= 6);
      put_alur(op, 7, 3, shift ? 6 : 2);
      store_l(7, model_alu(op, 32'hffff_8001, shift ? 32'd4 : 32'h0f0f_00f3));
      put_alui(op, 8, 1, shift ? 16'h0003 : 16'hff0f);
      store_l(8, model_alu(op, 32'h1234_5678, shift ? 32'd3 : 32'hffff_ff0f));
    end
    tgt = pc_a + 12;   // jmpd over a store that must not happen
    put_dir(8'h80, 0, tgt);
    targets.push_back(tgt);
    put_dir(8'h00, 1, BAD);
    put_dir(8'h01, 9, DATA);        // ldd.l
    put_inh(3, 0, 9);
    store_l(9, 32'hcafe_1235);
    put_dir(8'h03, 10, DATA + 4);   // ldd, zero extended
    put_inh(4, 0, 10);
    store_l(10, 32'h0000_9abb);
    put_dir(8'h02, 10, RES + 4 * res_n);   // std
    expect_half(RES + 4 * res_n, 16'h9abb);
    res_n++;
    put_imm2(8'h10, 11, 16'd5);
    put_imm2(8'h10, 12, 16'd5);
    put_imm2(8'h10, 13, 16'd3);
    put_imm2(8'h10, 14, 16'hffff);
    for (int c = 0; c < 3; c++) begin
      put_inh(2, rb_c[c], ra_c[c]);   // cmp
      for (int cond = 0; cond < 12; cond++) begin
        taken = branch_taken(cond, ca[c], cb[c]);
        mv    = 32'h4d00_0000 | (c << 8) | cond;
        put_imm2(8'(cond), 0, 16'd12);
        if (taken) begin
          targets.push_back(pc_a + 12);
        end
        put_ldi(15, mv);
        put_dir(8'h00, 15, MARK);
        if (!taken) begin
          expect_half(MARK, mv[31:16]);
          expect_half(MARK + 2, mv[15:0]);
        end
      end
    end
    emit(16'h0000);   // undefined mode
  endtask

  always @(posedge csi_clk) begin
    if (rsi_reset_n) begin
      assert (!(avm_m0_read && avm_m0_write)) else begin
        errors++;
        $display("read and write both high at %0t", $time);
      end
      if (avm_m0_read || avm_m0_write) begin
        assert (avm_m0_byteenable === 2'b11) else begin
          errors++;
          $display("Error at %0t: avm_m0_byteenable = %b, expected %b",
                   $time, avm_m0_byteenable, 2'b11);
        end
      end
      if (p_busy) begin
        assert (avm_m0_address === p_addr && avm_m0_read === p_rd && avm_m0_write === p_wr
                && avm_m0_writedata === p_wd) else begin
          errors++;
          $display("bus outputs changed under waitrequest at %0t", $time);
        end
      end
      if (avm_m0_read && !avm_m0_waitrequest && (avm_m0_address - BASE) < (DATA - BASE)) begin
        if (!fetch_seen) begin
          assert (avm_m0_address == BASE) else begin
            errors++;
            $display("Error at %0t: avm_m0_address = %h, expected %h",
                     $time, avm_m0_address, BASE);
          end
        end else if (avm_m0_address != last_fetch + 2) begin
          if (targets.size() == 0) begin
            errors++;
            $display("fetch jumped to %h without a branch at %0t", avm_m0_address, $time);
          end else begin
            assert (avm_m0_address == targets[0]) else begin
              errors++;
              $display("Error at %0t: avm_m0_address = %h, expected %h",
                       $time, avm_m0_address, targets[0]);
            end
            void'(targets.pop_front());
          end
        end
        fetch_seen = 1'b1;
        last_fetch = avm_m0_address;
      end
      if (avm_m0_write && !avm_m0_waitrequest) begin
        if (exp_addr.size() == 0) begin
          errors++;
          $display("unexpected store of %h to %h at %0t", avm_m0_writedata, avm_m0_address,
                   $time);
        end else begin
          assert (avm_m0_address == exp_addr[0]) else begin
            errors++;
            $display("Error at %0t: avm_m0_address = %h, expected %h",
                     $time, avm_m0_address, exp_addr[0]);
          end
          assert (avm_m0_writedata == exp_data[0]) else begin
            errors++;
            $display("Error at %0t: avm_m0_writedata = %h, expected %h",
                     $time, avm_m0_writedata, exp_data[0]);
          end
          void'(exp_addr.pop_front());
          void'(exp_data.pop_front());
        end
      end
    end
    p_busy = rsi_reset_n && (avm_m0_read || avm_m0_write) && avm_m0_waitrequest;
    p_addr = avm_m0_address;
    p_rd   = avm_m0_read;
    p_wr   = avm_m0_write;
    p_wd   = avm_m0_writedata;
  end

  initial begin
    int cycles;
    errors      = 0;
    fetch_seen  = 1'b0;
    last_fetch  = '0;
    p_busy      = 1'b0;
    rsi_reset_n = 1'b0;
    @(negedge csi_clk);
    load_program();
    repeat (2) @(negedge csi_clk);
    rsi_reset_n = 1'b1;
    assert (!avm_m0_read && !avm_m0_write && !fault) else begin
      errors++;
      $display("read, write or fault high right after reset");
    end
    cycles = 0;
    while (!fault && cycles < TIMEOUT) begin
      @(posedge csi_clk);
      cycles++;
    end
    if (!fault) begin
      errors++;
      $display("timeout waiting for fault, state %s", i_dut.i_control.state.name());
    end else begin
      for (int i = 0; i < 50; i++) begin
        @(posedge csi_clk);
        assert (!avm_m0_read && !avm_m0_write && fault) else begin
          errors++;
          $display("bus activity or fault drop after fault at %0t", $time);
        end
      end
    end
    if (exp_addr.size() != 0) begin
      errors++;
      $display("%0d expected stores never happened", exp_addr.size());
    end
    if (targets.size() != 0) begin
      errors++;
      $display("%0d expected jumps never happened", targets.size());
    end
    $display("checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
src/bexkat_pkg.sv
src/bexkat_alu.sv
src/bexkat_regfile.sv
src/bexkat_bus_master.sv
src/bexkat_control.sv
src/bexkat_core.sv
dv/tb_bexkat_mem.sv
dv/tb_bexkat_core.sv

//--- Bender.yml
package:
  name: bexkat1

sources:
  - src/bexkat_pkg.sv
  - src/bexkat_alu.sv
  - src/bexkat_regfile.sv
  - src/bexkat_bus_master.sv
  - src/bexkat_control.sv
  - src/bexkat_core.sv
  - target: simulation
    files:
      - dv/tb_bexkat_mem.sv
      - dv/tb_bexkat_core.sv
